// ==== fetch_pkg.sv ====
package fetch_pkg;

  localparam int XLEN = 32;
  localparam int PARCEL_W = 16;

  localparam int QUEUE_DEPTH = 16;
  localparam int QUEUE_PTR_W = 4;
  localparam int QUEUE_ROOM_MIN = 2;  // Free entries needed before a fetch

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [PARCEL_W-1:0] parcel_t;

endpackage

// ==== rvc_expander.sv ====
`timescale 1ns/1ps

module rvc_expander import fetch_pkg::*; (
  input  parcel_t parcel,
  output word_t   instr
);

  logic [4:0]  rd_full;
  logic [4:0]  rs2_full;
  logic [4:0]  rd_p;   // x8..x15 register forms
  logic [4:0]  rs1_p;
  logic [11:0] j_off;  // C.J / C.JAL offset
  logic [12:0] b_off;  // C.BEQZ / C.BNEZ offset

  assign rd_full  = parcel[11:7];
  assign rs2_full = parcel[6:2];
  assign rd_p     = {2'b01, parcel[4:2]};
  assign rs1_p    = {2'b01, parcel[9:7]};
  assign j_off    = {parcel[12], parcel[8], parcel[10:9], parcel[6], parcel[7], parcel[2],
                     parcel[11], parcel[5:3], 1'b0};
  assign b_off    = {{5{parcel[12]}}, parcel[6:5], parcel[2], parcel[11:10], parcel[4:3],
                     1'b0};

  always_comb begin
    instr = '0;
    case (parcel[1:0])
      2'b00: begin
        case (parcel[15:13])
          3'b000: instr = {2'b00, parcel[10:7], parcel[12:11], parcel[5], parcel[6], 2'b00,
                           5'd2, 3'b000, rd_p, OPC_OP_IMM};  // C.ADDI4SPN
          3'b010: instr = {5'b00000, parcel[5], parcel[12:10], parcel[6], 2'b00,
                           rs1_p, 3'b010, rd_p, OPC_LOAD};  // C.LW
          3'b110: instr = {5'b00000, parcel[5], parcel[12], rd_p, rs1_p, 3'b010,
                           parcel[11:10], parcel[6], 2'b00, OPC_STORE};  // C.SW
          default: instr = '0;
        endcase
      end
      2'b01: begin
        case (parcel[15:13])
          3'b000: instr = {{7{parcel[12]}}, parcel[6:2], rd_full, 3'b000, rd_full,
                           OPC_OP_IMM};  // C.ADDI
          3'b001: instr = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}}, 5'd1,
                           OPC_JAL};  // C.JAL
          3'b010: instr = {{7{parcel[12]}}, parcel[6:2], 5'd0, 3'b000, rd_full,
                           OPC_OP_IMM};  // C.LI
          3'b011: begin
            if (rd_full == 5'd2) begin
              instr = {{3{parcel[12]}}, parcel[4:3], parcel[5], parcel[2], parcel[6], 4'b0000,
                       5'd2, 3'b000, 5'd2, OPC_OP_IMM};  // C.ADDI16SP
            end else begin
              instr = {{15{parcel[12]}}, parcel[6:2], rd_full, OPC_LUI};
            end
          end
          3'b100: begin
            case (parcel[11:10])
              2'b00: instr = {6'b000000, parcel[12], parcel[6:2], rs1_p, 3'b101, rs1_p,
                              OPC_OP_IMM};  // C.SRLI
              2'b01: instr = {6'b010000, parcel[12], parcel[6:2], rs1_p, 3'b101, rs1_p,
                              OPC_OP_IMM};  // C.SRAI
              2'b10: instr = {{7{parcel[12]}}, parcel[6:2], rs1_p, 3'b111, rs1_p,
                              OPC_OP_IMM};  // C.ANDI
              default: begin
                if (!parcel[12]) begin
                  case (parcel[6:5])
                    2'b00: instr = {7'b0100000, rd_p, rs1_p, 3'b000, rs1_p, OPC_OP};  // C.SUB
                    2'b01: instr = {7'b0000000, rd_p, rs1_p, 3'b100, rs1_p, OPC_OP};
                    2'b10: instr = {7'b0000000, rd_p, rs1_p, 3'b110, rs1_p, OPC_OP};
                    default: instr = {7'b0000000, rd_p, rs1_p, 3'b111, rs1_p, OPC_OP};
                  endcase
                end
              end
            endcase
          end
          3'b101: instr = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}}, 5'd0,
                           OPC_JAL};  // C.J
          default: instr = {b_off[12], b_off[10:5], 5'd0, rs1_p, {2'b00, parcel[13]},
                            b_off[4:1], b_off[11], OPC_BRANCH};  // C.BEQZ, C.BNEZ
        endcase
      end
      2'b10: begin
        case (parcel[15:13])
          3'b000: instr = {6'b000000, parcel[12], parcel[6:2], rd_full, 3'b001, rd_full,
                           OPC_OP_IMM};  // C.SLLI
          3'b010: instr = {4'b0000, parcel[3:2], parcel[12], parcel[6:4], 2'b00, 5'd2, 3'b010,
                           rd_full, OPC_LOAD};  // C.LWSP
          3'b100: begin
            if (rs2_full == 5'd0) begin
              instr = {12'd0, rd_full, 3'b000, {4'b0000, parcel[12]}, OPC_JALR};  // C.JR, C.JALR
            end else if (!parcel[12]) begin
              instr = {7'b0000000, rs2_full, 5'd0, 3'b000, rd_full, OPC_OP};  // C.MV
            end else begin
              instr = {7'b0000000, rs2_full, rd_full, 3'b000, rd_full, OPC_OP};  // C.ADD
            end
          end
          3'b110: instr = {4'b0000, parcel[8:7], parcel[12], rs2_full, 5'd2, 3'b010,
                           parcel[11:9], 2'b00, OPC_STORE};  // C.SWSP
          default: instr = '0;
        endcase
      end
      default: instr = '0;  // Not a compressed parcel
    endcase
  end

endmodule

// ==== branch_predecode.sv ====
`timescale 1ns/1ps

module branch_predecode import fetch_pkg::*; (
  input  word_t instr,
  input  word_t pc,
  output logic  taken,
  output word_t target
);

  logic  is_jal;
  logic  is_branch;
  word_t imm_j;
  word_t imm_b;

  assign is_jal    = instr[6:0] == OPC_JAL;
  assign is_branch = instr[6:0] == OPC_BRANCH;

  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  // Backward branches predicted taken
  assign taken  = is_jal || (is_branch && instr[31]);
  assign target = pc + (is_jal ? imm_j : imm_b);

endmodule

// ==== instr_aligner.sv ====
`timescale 1ns/1ps

module instr_aligner import fetch_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  flush,
  input  logic  word_valid,
  input  word_t word_data,
  input  word_t word_addr,
  input  logic  start_hi,
  output logic  slot0_valid,
  output word_t slot0_instr,
  output word_t slot0_pc,
  output logic  slot0_compressed,
  output logic  slot0_taken,
  output logic  slot1_valid,
  output word_t slot1_instr,
  output word_t slot1_pc,
  output logic  slot1_compressed,
  output logic  slot1_taken,
  output logic  redirect_valid,
  output word_t redirect_pc
);

  parcel_t lo_parcel;
  parcel_t hi_parcel;
  parcel_t held_parcel;  // Lower half of a straddling instruction
  logic    held_valid;
  word_t   lo_exp;
  word_t   hi_exp;
  logic    lo_full;
  logic    hi_full;
  logic    first_ok;
  logic    hi_avail;
  logic    hi_comp_ok;
  logic    hold_next;
  logic    pd0_taken;
  logic    pd1_taken;
  word_t   pd0_target;
  word_t   pd1_target;

  assign lo_parcel = word_data[15:0];
  assign hi_parcel = word_data[31:16];
  assign lo_full   = lo_parcel[1:0] == 2'b11;
  assign hi_full   = hi_parcel[1:0] == 2'b11;

  rvc_expander lo_exp_i (.parcel(lo_parcel), .instr(lo_exp));
  rvc_expander hi_exp_i (.parcel(hi_parcel), .instr(hi_exp));

  assign first_ok   = held_valid || !start_hi;            // Something starts at or before lo
  assign hi_avail   = held_valid || start_hi || !lo_full;  // Upper parcel not yet consumed
  assign hi_comp_ok = hi_avail && !hi_full;

  always_comb begin
    slot0_instr      = hi_exp;
    slot0_pc         = word_addr + word_t'(2);
    slot0_compressed = 1'b1;
    if (held_valid) begin
      slot0_instr      = {lo_parcel, held_parcel};
      slot0_pc         = word_addr - word_t'(2);
      slot0_compressed = 1'b0;
    end else if (!start_hi) begin
      slot0_instr      = lo_full ? word_data : lo_exp;
      slot0_pc         = word_addr;
      slot0_compressed = !lo_full;
    end
  end

  assign slot0_valid = word_valid && (first_ok || hi_comp_ok);

  assign slot1_instr      = hi_exp;
  assign slot1_pc         = word_addr + word_t'(2);
  assign slot1_compressed = 1'b1;
  assign slot1_valid      = word_valid && first_ok && hi_comp_ok && !slot0_taken;

  branch_predecode pd0_i (
    .instr (slot0_instr),
    .pc    (slot0_pc),
    .taken (pd0_taken),
    .target(pd0_target)
  );

  branch_predecode pd1_i (
    .instr (slot1_instr),
    .pc    (slot1_pc),
    .taken (pd1_taken),
    .target(pd1_target)
  );

  assign slot0_taken    = slot0_valid && pd0_taken;
  assign slot1_taken    = slot1_valid && pd1_taken;
  assign redirect_valid = slot0_taken || slot1_taken;
  assign redirect_pc    = slot0_taken ? pd0_target : pd1_target;

  assign hold_next = hi_avail && hi_full && !slot0_taken;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      held_valid <= 1'b0;
    end else if (word_valid) begin
      held_valid <= hold_next;
    end
  end

  always_ff @(posedge clk) begin
    if (word_valid && hold_next) begin
      held_parcel <= hi_parcel;
    end
  end

  // A held half continues into the lower parcel
  assert property (@(posedge clk) disable iff (rst) (word_valid && held_valid) |-> !start_hi)
    else $error("instr_aligner: held half followed by a word starting at the upper parcel");

endmodule

// ==== instr_queue.sv ====
`timescale 1ns/1ps

module instr_queue import fetch_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  flush,
  input  logic  slot0_valid,
  input  word_t slot0_instr,
  input  word_t slot0_pc,
  input  logic  slot0_compressed,
  input  logic  slot0_taken,
  input  logic  slot1_valid,
  input  word_t slot1_instr,
  input  word_t slot1_pc,
  input  logic  slot1_compressed,
  input  logic  slot1_taken,
  input  logic  rob_ready,
  output logic  has_room,
  output logic  out_valid,
  output word_t out_instr,
  output word_t out_pc,
  output logic  out_compressed,
  output logic  out_pred_taken
);

  word_t q_instr [QUEUE_DEPTH];
  word_t q_pc    [QUEUE_DEPTH];
  logic  q_comp  [QUEUE_DEPTH];
  logic  q_taken [QUEUE_DEPTH];

  logic [QUEUE_PTR_W-1:0] head;
  logic [QUEUE_PTR_W-1:0] tail;
  logic [QUEUE_PTR_W-1:0] tail_plus1;
  logic [QUEUE_PTR_W:0]   count;
  logic [QUEUE_PTR_W:0]   free_cnt;
  logic [1:0]             wr_cnt;
  logic                   pop;

  assign wr_cnt     = {1'b0, slot0_valid} + {1'b0, slot1_valid};
  assign pop        = rob_ready && (count != '0);
  assign tail_plus1 = tail + 1'b1;
  assign free_cnt   = (QUEUE_PTR_W+1)'(QUEUE_DEPTH) - count;
  assign has_room   = free_cnt >= (QUEUE_PTR_W+1)'(QUEUE_ROOM_MIN);

  always_ff @(posedge clk) begin
    if (slot0_valid) begin
      q_instr[tail] <= slot0_instr;
      q_pc[tail]    <= slot0_pc;
      q_comp[tail]  <= slot0_compressed;
      q_taken[tail] <= slot0_taken;
    end
    if (slot1_valid) begin  // Always behind slot0
      q_instr[tail_plus1] <= slot1_instr;
      q_pc[tail_plus1]    <= slot1_pc;
      q_comp[tail_plus1]  <= slot1_compressed;
      q_taken[tail_plus1] <= slot1_taken;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      tail      <= tail + QUEUE_PTR_W'(wr_cnt);
      head      <= head + QUEUE_PTR_W'(pop);
      count     <= count + (QUEUE_PTR_W+1)'(wr_cnt) - (QUEUE_PTR_W+1)'(pop);
      out_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      out_instr      <= q_instr[head];
      out_pc         <= q_pc[head];
      out_compressed <= q_comp[head];
      out_pred_taken <= q_taken[head];
    end
  end

  // Fetch only requests with enough room reserved
  assert property (@(posedge clk) disable iff (rst || flush)
    (wr_cnt != 2'd0) |-> (free_cnt >= (QUEUE_PTR_W+1)'(wr_cnt)))
    else $error("instr_queue: write with %0d free entries", free_cnt);

endmodule

// ==== fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  flush,
  input  word_t flush_pc,
  input  logic  has_room,
  input  logic  redirect_valid,
  input  word_t redirect_pc,
  input  logic  imem_rsp_valid,
  input  word_t imem_rsp_addr,
  input  word_t imem_rsp_data,
  output logic  imem_req,
  output word_t imem_addr,
  output logic  word_valid,
  output word_t word_data,
  output word_t word_addr,
  output logic  start_hi
);

  word_t pc;         // Fetch pc that may sit on a halfword
  word_t exp_addr;   // Word address of the outstanding request
  logic  in_flight;
  logic  drop_rsp;   // Outstanding response predates a flush
  logic  rsp_match;
  logic  issue;

  assign rsp_match  = imem_rsp_valid && in_flight && (imem_rsp_addr == exp_addr);
  assign word_valid = rsp_match && !drop_rsp && !flush;
  assign word_data  = imem_rsp_data;
  assign word_addr  = exp_addr;
  assign start_hi   = pc[1];
  assign imem_addr  = exp_addr;

  assign issue = !in_flight && !imem_req && has_room && !flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= '0;
      imem_req  <= 1'b0;
      in_flight <= 1'b0;
      drop_rsp  <= 1'b0;
    end else begin
      imem_req <= issue;
      if (imem_req) begin
        in_flight <= 1'b1;
      end else if (rsp_match) begin
        in_flight <= 1'b0;
      end
      if (flush) begin
        pc       <= flush_pc;
        drop_rsp <= imem_req || (in_flight && !rsp_match);
      end else begin
        if (rsp_match) begin
          drop_rsp <= 1'b0;
        end
        if (word_valid) begin
          pc <= redirect_valid ? redirect_pc : exp_addr + word_t'(4);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      exp_addr <= {pc[XLEN-1:2], 2'b00};
    end
  end

  // Restart pc lies on a halfword
  assert property (@(posedge clk) disable iff (rst) flush |-> !flush_pc[0])
    else $error("fetch_ctrl: flush pc %h is not halfword aligned", flush_pc);

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  output logic  imem_req,
  output word_t imem_addr,
  input  logic  imem_rsp_valid,
  input  word_t imem_rsp_addr,
  input  word_t imem_rsp_data,
  input  logic  rob_ready,
  output logic  out_valid,
  output word_t out_instr,
  output word_t out_pc,
  output logic  out_compressed,
  output logic  out_pred_taken,
  input  logic  flush,
  input  word_t flush_pc
);

  logic  word_valid;
  word_t word_data;
  word_t word_addr;
  logic  start_hi;
  logic  has_room;
  logic  redirect_valid;
  word_t redirect_pc;

  logic  slot0_valid;
  word_t slot0_instr;
  word_t slot0_pc;
  logic  slot0_compressed;
  logic  slot0_taken;
  logic  slot1_valid;
  word_t slot1_instr;
  word_t slot1_pc;
  logic  slot1_compressed;
  logic  slot1_taken;

  fetch_ctrl ctrl_i (
    .clk           (clk),
    .rst           (rst),
    .flush         (flush),
    .flush_pc      (flush_pc),
    .has_room      (has_room),
    .redirect_valid(redirect_valid),
    .redirect_pc   (redirect_pc),
    .imem_rsp_valid(imem_rsp_valid),
    .imem_rsp_addr (imem_rsp_addr),
    .imem_rsp_data (imem_rsp_data),
    .imem_req      (imem_req),
    .imem_addr     (imem_addr),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .word_addr     (word_addr),
    .start_hi      (start_hi)
  );

  instr_aligner aligner_i (
    .clk             (clk),
    .rst             (rst),
    .flush           (flush),
    .word_valid      (word_valid),
    .word_data       (word_data),
    .word_addr       (word_addr),
    .start_hi        (start_hi),
    .slot0_valid     (slot0_valid),
    .slot0_instr     (slot0_instr),
    .slot0_pc        (slot0_pc),
    .slot0_compressed(slot0_compressed),
    .slot0_taken     (slot0_taken),
    .slot1_valid     (slot1_valid),
    .slot1_instr     (slot1_instr),
    .slot1_pc        (slot1_pc),
    .slot1_compressed(slot1_compressed),
    .slot1_taken     (slot1_taken),
    .redirect_valid  (redirect_valid),
    .redirect_pc     (redirect_pc)
  );

  instr_queue queue_i (
    .clk             (clk),
    .rst             (rst),
    .flush           (flush),
    .slot0_valid     (slot0_valid),
    .slot0_instr     (slot0_instr),
    .slot0_pc        (slot0_pc),
    .slot0_compressed(slot0_compressed),
    .slot0_taken     (slot0_taken),
    .slot1_valid     (slot1_valid),
    .slot1_instr     (slot1_instr),
    .slot1_pc        (slot1_pc),
    .slot1_compressed(slot1_compressed),
    .slot1_taken     (slot1_taken),
    .rob_ready       (rob_ready),
    .has_room        (has_room),
    .out_valid       (out_valid),
    .out_instr       (out_instr),
    .out_pc          (out_pc),
    .out_compressed  (out_compressed),
    .out_pred_taken  (out_pred_taken)
  );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== tb_model.svh ====
word_t       lfsr_state = 32'hcfbe_7517;
logic [15:0] prog_hw [512];
word_t       mem [256];
int          n_instr;
int          start_hw [512];  // Halfword index of each instruction
// Kinds 0 ADDI, 1 C.ADDI, 2 C.LI, 3 C.MV, 4 C.LW, 5 C.J, 6 C.BEQZ, 7 BEQ, 8 JAL
int          kind [512];
int          idx_at [512];
word_t       exp_instr [512];  // 32-bit form
logic        is_comp [512];
logic        is_taken [512];
word_t       jump_off [512];

function automatic int lfsr_bits(int n);
  int v;
  int b;
  v = 0;
  for (b = 0; b < n; b++) begin
    v = (v << 1) | int'(lfsr_state[0]);
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
  end
  return v;
endfunction

function automatic logic is_wide(int k);
  return k == 0 || k == 7 || k == 8;
endfunction

function automatic word_t beq_word(word_t o, logic [4:0] rs2, logic [4:0] rs1);
  return {o[12], o[10:5], rs2, rs1, 3'b000, o[4:1], o[11], 7'b1100011};
endfunction

function automatic word_t jal_word(word_t o, logic [4:0] rd);
  return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
endfunction

task automatic gen_program();
  int          pos;
  int          k;
  int          t;
  int          tpos;
  int          i;
  logic [4:0]  r1;
  logic [4:0]  r2;
  logic [5:0]  i6;
  logic [4:0]  u5;
  word_t       w;
  word_t       o;
  logic [15:0] c;
  pos = 0;
  n_instr = 0;
  while (pos < 512) begin
    k = lfsr_bits(4);
    k = (k < 3 || k == 15) ? 0 : (k < 11) ? (k - 1) / 2 : k - 6;
    if (pos == 511 && is_wide(k)) k = 1;  // No straddle across the wrap
    start_hw[n_instr] = pos;
    kind[n_instr] = k;
    idx_at[pos] = n_instr;
    pos += is_wide(k) ? 2 : 1;
    n_instr++;
  end
  for (i = 0; i < n_instr; i++) begin
    r1 = 5'(lfsr_bits(5));
    r2 = 5'(lfsr_bits(5));
    i6 = 6'(lfsr_bits(6));
    u5 = 5'(lfsr_bits(5));
    t = i + lfsr_bits(6) - 32;  // Target instruction forward or backward
    if (t == i) t = i + 1;
    tpos = start_hw[(t + n_instr) % n_instr] + ((t < 0) ? -512 : ((t >= n_instr) ? 512 : 0));
    o = word_t'(2 * (tpos - start_hw[i]));
    jump_off[i] = o;
    is_taken[i] = 1'b0;
    c = '0;
    case (kind[i])
      1: begin
        c = {3'b000, i6[5], r1, i6[4:0], 2'b01};
        w = {{6{i6[5]}}, i6, r1, 3'b000, r1, 7'b0010011};
      end
      2: begin
        c = {3'b010, i6[5], r1, i6[4:0], 2'b01};
        w = {{6{i6[5]}}, i6, 5'd0, 3'b000, r1, 7'b0010011};
      end
      3: begin
        if (r2 == 5'd0) r2 = 5'd1;  // Zero rs2 would mean C.JR
        c = {4'b1000, r1, r2, 2'b10};
        w = {7'd0, r2, 5'd0, 3'b000, r1, 7'b0110011};
      end
      4: begin
        c = {3'b010, u5[3:1], r1[2:0], u5[0], u5[4], r2[2:0], 2'b00};
        w = {5'd0, u5, 2'b00, 2'b01, r1[2:0], 3'b010, 2'b01, r2[2:0], 7'b0000011};
      end
      5: begin
        c = {3'b101, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
        w = jal_word(o, 5'd0);
        is_taken[i] = 1'b1;
      end
      6: begin
        c = {3'b110, o[8], o[4:3], r1[2:0], o[7:6], o[2:1], o[5], 2'b01};
        w = beq_word(o, 5'd0, {2'b01, r1[2:0]});
        is_taken[i] = o[31];
      end
      7: begin
        w = beq_word(o, r2, r1);
        is_taken[i] = o[31];
      end
      8: begin
        w = jal_word(o, r1);
        is_taken[i] = 1'b1;
      end
      default: w = {12'(lfsr_bits(12)), r1, 3'b000, r2, 7'b0010011};
    endcase
    is_comp[i] = !is_wide(kind[i]);
    exp_instr[i] = w;
    if (is_comp[i]) begin
      prog_hw[start_hw[i]] = c;
    end else begin
      prog_hw[start_hw[i]] = w[15:0];
      prog_hw[start_hw[i] + 1] = w[31:16];
    end
  end
  for (i = 0; i < 256; i++) begin
    mem[i] = {prog_hw[2 * i + 1], prog_hw[2 * i]};
  end
endtask

// ==== tb_fetch_unit.sv ====
`timescale 1ns/1ps

module tb_fetch_unit import fetch_pkg::*; ();

  localparam int NUM_INSTR       = 2000;
  localparam int WATCHDOG_CYCLES = NUM_INSTR * 20;
  localparam int CLK_PERIOD_NS   = 10;

  logic  clk;
  logic  rst;
  logic  imem_req;
  word_t imem_addr;
  logic  imem_rsp_valid;
  word_t imem_rsp_addr;
  word_t imem_rsp_data;
  logic  rob_ready;
  logic  out_valid;
  word_t out_instr;
  word_t out_pc;
  logic  out_compressed;
  logic  out_pred_taken;
  logic  flush;
  word_t flush_pc;

  bit    started = 1'b0;
  logic  pending;    // Request waiting for its response
  word_t req_addr;
  int    rsp_wait;
  int    flush_wait;
  int    hold_low;
  logic  idle_next;  // Cycle after a flush
  word_t model_pc;
  int    n_checked;
  int    n_failed;

  `include "tb_model.svh"

  tb_clock clk_i (.clk(clk), .rst(rst));

  fetch_unit dut_i (.*);

  task automatic value_error(string name, word_t expected, word_t actual);
    n_failed++;
    $display("error %s at instruction %0d: expected %h, actual %h",
             name, n_checked, expected, actual);
    $display("Simulation failed");
    $fatal(1, "%s mismatch", name);
  endtask

  task automatic plain_error(string msg);
    n_failed++;
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_outputs();
    int i;
    i = idx_at[model_pc[9:1]];
    if (idle_next) begin
      assert (!out_valid) else plain_error("out_valid high in the cycle after a flush");
      idle_next = 1'b0;
    end else if (out_valid) begin
      assert (out_pc == model_pc) else value_error("dispatch pc", model_pc, out_pc);
      assert (out_instr == exp_instr[i])
        else value_error("dispatch instr", exp_instr[i], out_instr);
      assert (out_compressed == is_comp[i])
        else value_error("compressed flag", word_t'(is_comp[i]), word_t'(out_compressed));
      assert (out_pred_taken == is_taken[i])
        else value_error("predicted taken", word_t'(is_taken[i]), word_t'(out_pred_taken));
      model_pc = is_taken[i] ? model_pc + jump_off[i] : model_pc + (is_comp[i] ? 32'd2 : 32'd4);
      n_checked++;
    end
  endtask

  task automatic serve_memory();
    assert (!(imem_req && pending))
      else plain_error("memory request issued while another one was outstanding");
    imem_rsp_valid = 1'b0;
    if (pending) begin
      if (rsp_wait == 0) begin
        imem_rsp_valid = 1'b1;
        imem_rsp_addr = req_addr;
        imem_rsp_data = mem[req_addr[9:2]];
        pending = 1'b0;
      end else begin
        rsp_wait--;
      end
    end else if (imem_req) begin
      pending = 1'b1;
      req_addr = imem_addr;
      rsp_wait = lfsr_bits(2);  // Answer after 1 to 4 cycles
    end
    if (!imem_rsp_valid && lfsr_bits(3) == 0) begin
      imem_rsp_valid = 1'b1;  // Stale address with junk data
      imem_rsp_addr = req_addr ^ 32'h0000_0400;
      imem_rsp_data = word_t'(lfsr_bits(32));
    end
  endtask

  task automatic drive_backend();
    flush = 1'b0;
    if (flush_wait == 0) begin
      flush = 1'b1;
      flush_pc = word_t'(2 * start_hw[lfsr_bits(9) % n_instr]);
      model_pc = flush_pc;
      idle_next = 1'b1;
      flush_wait = 44 + lfsr_bits(5);
    end else begin
      flush_wait--;
    end
    if (hold_low > 0) begin
      rob_ready = 1'b0;  // Long back-pressure stretch
      hold_low--;
    end else begin
      rob_ready = lfsr_bits(2) != 0;
      if (lfsr_bits(6) == 0) hold_low = 24;
    end
  endtask

  always @(negedge clk) begin
    if (started && !rst) begin
      check_outputs();
      serve_memory();
      drive_backend();
    end
  end

  initial begin
    imem_rsp_valid = 1'b0;
    imem_rsp_addr = '0;
    imem_rsp_data = '0;
    rob_ready = 1'b0;
    flush = 1'b0;
    flush_pc = '0;
    pending = 1'b0;
    req_addr = '0;
    rsp_wait = 0;
    flush_wait = 44;
    hold_low = 0;
    idle_next = 1'b0;
    model_pc = '0;
    n_checked = 0;
    n_failed = 0;
    gen_program();
    started = 1'b1;
    wait (n_checked >= NUM_INSTR);
    if (n_failed == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "checks failed");
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Timeout: %0d of %0d instructions dispatched after %0d cycles",
             n_checked, NUM_INSTR, WATCHDOG_CYCLES);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== all.f ====
+incdir+.
fetch_pkg.sv
rvc_expander.sv
branch_predecode.sv
instr_aligner.sv
instr_queue.sv
fetch_ctrl.sv
fetch_unit.sv
tb_clock.sv
tb_fetch_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_unit
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps
PASS_MSG  ?= Simulation completed successfully
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
